// ==== common/bus_pkg.sv ====
package bus_pkg;

    // address and data width of every bus
    localparam int word_w = 32;

    // one strobe bit per byte lane
    localparam int strb_w = 4;

    // memory bus burst length, beats minus one
    localparam int len_w = 3;

    // beats in a cache line fill
    localparam int line_words = 4;

    localparam logic [len_w-1:0] len_single = '0;
    localparam logic [len_w-1:0] len_line = len_w'(line_words - 1);

endpackage

// ==== common/addr_map_pkg.sv ====
package addr_map_pkg;

    // unmapped kernel segments
    localparam logic [31:0] kseg0_base = 32'h8000_0000;
    localparam logic [31:0] kseg1_base = 32'hA000_0000;
    localparam logic [31:0] kseg2_base = 32'hC000_0000;

    // config_k0 code that makes kseg0 cacheable
    localparam logic [2:0] k0_cached = 3'd3;

    // 16 lines of 16 bytes each
    localparam int index_w = 4;
    localparam int offset_w = 4;
    localparam int tag_w = 32 - index_w - offset_w;

    // word select inside a line
    localparam int word_sel_w = offset_w - 2;
    localparam int line_count = 1 << index_w;

endpackage

// ==== logic/addr_translate.sv ====
`timescale 1ns/1ps

module addr_translate
    import bus_pkg::*;
    import addr_map_pkg::*;
(
    input  logic              ireq_valid,
    input  logic [word_w-1:0] ireq_addr,
    input  logic              dreq_valid,
    input  logic [word_w-1:0] dreq_addr,
    input  logic [strb_w-1:0] dreq_strb,
    input  logic [2:0]        config_k0,
    output logic              i_valid,
    output logic [word_w-1:0] i_paddr,
    output logic              i_uncached,
    output logic              d_valid,
    output logic [word_w-1:0] d_paddr,
    output logic              d_uncached,
    output logic              exc_adel,
    output logic              exc_ades
);
    logic d_misaligned;

    // kseg0 and kseg1 both map onto the low 512 MB
    function automatic logic [word_w-1:0] to_paddr(input logic [word_w-1:0] va);
        if (va >= kseg0_base && va < kseg2_base) begin
            return {3'b000, va[word_w-4:0]};
        end
        return va;
    endfunction

    function automatic logic is_uncached(input logic [word_w-1:0] va, input logic [2:0] k0);
        if (va >= kseg1_base && va < kseg2_base) begin
            return 1'b1;
        end
        if (va >= kseg0_base && va < kseg1_base) begin
            return k0 != k0_cached;
        end
        return 1'b0;
    endfunction

    // loads always move a full word, stores size by strobe count
    always_comb begin
        case ($countones(dreq_strb))
            0, 4: d_misaligned = dreq_addr[1:0] != 2'b00;
            2: d_misaligned = dreq_addr[0];
            default: d_misaligned = 1'b0;
        endcase
    end

    assign i_valid = ireq_valid;
    assign i_paddr = to_paddr(ireq_addr);
    assign i_uncached = is_uncached(ireq_addr, config_k0);

    // a faulting request never reaches the data cache
    assign d_valid = dreq_valid && !d_misaligned;
    assign d_paddr = to_paddr(dreq_addr);
    assign d_uncached = is_uncached(dreq_addr, config_k0);

    assign exc_adel = dreq_valid && d_misaligned && dreq_strb == '0;
    assign exc_ades = dreq_valid && d_misaligned && dreq_strb != '0;

endmodule

// ==== icache/icache.sv ====
`timescale 1ns/1ps

module icache
    import bus_pkg::*;
    import addr_map_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic [word_w-1:0] req_paddr,
    input  logic              req_uncached,
    output logic              resp_data_ok,
    output logic [word_w-1:0] resp_data,
    output logic              creq_valid,
    output logic              creq_write,
    output logic [word_w-1:0] creq_addr,
    output logic [len_w-1:0]  creq_len,
    output logic [strb_w-1:0] creq_strb,
    output logic [word_w-1:0] creq_wdata,
    input  logic              cresp_ready,
    input  logic              cresp_last,
    input  logic [word_w-1:0] cresp_rdata
);
    logic [tag_w-1:0]      tag_q [line_count];
    logic [line_count-1:0] valid_q;
    logic [word_w-1:0]     data_q [line_count * line_words];
    logic [tag_w-1:0]      req_tag;
    logic [index_w-1:0]    req_index;
    logic [word_sel_w-1:0] req_word;
    logic [word_sel_w-1:0] beat_q;
    logic                  fill_q;
    logic                  hit;
    logic                  accept;
    logic                  beat_done;

    assign req_tag = req_paddr[word_w-1 -: tag_w];
    assign req_index = req_paddr[offset_w +: index_w];
    assign req_word = req_paddr[offset_w-1:2];
    assign hit = valid_q[req_index] && tag_q[req_index] == req_tag && !req_uncached;

    // the data_ok cycle still shows the old request
    assign accept = req_valid && !creq_valid && !resp_data_ok;
    assign beat_done = creq_valid && cresp_ready;

    // read-only port
    assign creq_write = 1'b0;
    assign creq_strb = '0;
    assign creq_wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            creq_valid <= 1'b0;
            resp_data_ok <= 1'b0;
            valid_q <= '0;
            beat_q <= '0;
            fill_q <= 1'b0;
        end else begin
            resp_data_ok <= 1'b0;
            if (accept && hit) begin
                resp_data_ok <= 1'b1;
            end else if (accept) begin
                creq_valid <= 1'b1;
                beat_q <= '0;
                fill_q <= !req_uncached;
            end
            if (beat_done) begin
                beat_q <= beat_q + 1'b1;
                if (cresp_last) begin
                    creq_valid <= 1'b0;
                    resp_data_ok <= 1'b1;
                    if (fill_q) begin
                        valid_q[req_index] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !req_uncached) begin
            creq_addr <= {req_paddr[word_w-1:offset_w], {offset_w{1'b0}}};
            creq_len <= len_line;
        end else if (accept) begin
            creq_addr <= {req_paddr[word_w-1:2], 2'b00};
            creq_len <= len_single;
        end
        if (accept && hit) begin
            resp_data <= data_q[{req_index, req_word}];
        end
        // fill runs from the line base, catch the wanted word on the way
        if (beat_done) begin
            if (fill_q) begin
                data_q[{req_index, beat_q}] <= cresp_rdata;
            end
            if (!fill_q || beat_q == req_word) begin
                resp_data <= cresp_rdata;
            end
            if (fill_q && cresp_last) begin
                tag_q[req_index] <= req_tag;
            end
        end
    end

    // core must hold the fetch until it is answered
    a_ok_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n) resp_data_ok |-> req_valid
    );

endmodule

// ==== dcache/dcache.sv ====
`timescale 1ns/1ps

module dcache
    import bus_pkg::*;
    import addr_map_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic [word_w-1:0] req_paddr,
    input  logic              req_uncached,
    input  logic [strb_w-1:0] req_strb,
    input  logic [word_w-1:0] req_wdata,
    output logic              resp_data_ok,
    output logic [word_w-1:0] resp_data,
    output logic              creq_valid,
    output logic              creq_write,
    output logic [word_w-1:0] creq_addr,
    output logic [len_w-1:0]  creq_len,
    output logic [strb_w-1:0] creq_strb,
    output logic [word_w-1:0] creq_wdata,
    input  logic              cresp_ready,
    input  logic              cresp_last,
    input  logic [word_w-1:0] cresp_rdata
);
    logic [tag_w-1:0]      tag_q [line_count];
    logic [line_count-1:0] valid_q;
    logic [word_w-1:0]     data_q [line_count * line_words];
    logic [tag_w-1:0]      req_tag;
    logic [index_w-1:0]    req_index;
    logic [word_sel_w-1:0] req_word;
    logic [word_sel_w-1:0] beat_q;
    logic                  fill_q;
    logic                  is_write;
    logic                  start_fill;
    logic                  tag_match;
    logic                  hit;
    logic                  accept;
    logic                  beat_done;

    assign req_tag = req_paddr[word_w-1 -: tag_w];
    assign req_index = req_paddr[offset_w +: index_w];
    assign req_word = req_paddr[offset_w-1:2];
    assign is_write = req_strb != '0;
    assign tag_match = valid_q[req_index] && tag_q[req_index] == req_tag;
    assign hit = tag_match && !req_uncached;

    // only cached reads allocate
    assign start_fill = !req_uncached && !is_write;
    assign accept = req_valid && !creq_valid && !resp_data_ok;
    assign beat_done = creq_valid && cresp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            creq_valid <= 1'b0;
            resp_data_ok <= 1'b0;
            valid_q <= '0;
            beat_q <= '0;
            fill_q <= 1'b0;
        end else begin
            resp_data_ok <= 1'b0;
            if (accept && hit && !is_write) begin
                resp_data_ok <= 1'b1;
            end else if (accept) begin
                creq_valid <= 1'b1;
                beat_q <= '0;
                fill_q <= start_fill;
            end
            if (beat_done) begin
                beat_q <= beat_q + 1'b1;
                if (cresp_last) begin
                    creq_valid <= 1'b0;
                    resp_data_ok <= 1'b1;
                    if (fill_q) begin
                        valid_q[req_index] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            creq_write <= is_write;
            creq_strb <= req_strb;
            creq_wdata <= req_wdata;
            if (start_fill) begin
                creq_addr <= {req_paddr[word_w-1:offset_w], {offset_w{1'b0}}};
                creq_len <= len_line;
            end else begin
                creq_addr <= {req_paddr[word_w-1:2], 2'b00};
                creq_len <= len_single;
            end
        end
        // write-through, so a resident copy is patched in place
        if (accept && is_write && tag_match) begin
            for (int b = 0; b < strb_w; b++) begin
                if (req_strb[b]) begin
                    data_q[{req_index, req_word}][8*b +: 8] <= req_wdata[8*b +: 8];
                end
            end
        end else if (accept && hit) begin
            resp_data <= data_q[{req_index, req_word}];
        end
        if (beat_done) begin
            if (fill_q) begin
                data_q[{req_index, beat_q}] <= cresp_rdata;
            end
            if (!fill_q || beat_q == req_word) begin
                resp_data <= cresp_rdata;
            end
            if (fill_q && cresp_last) begin
                tag_q[req_index] <= req_tag;
            end
        end
    end

    // stores never burst
    a_write_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        creq_valid && creq_write |-> creq_len == len_single && (!cresp_ready || cresp_last)
    );

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ic_creq_valid,
    input  logic              ic_creq_write,
    input  logic [word_w-1:0] ic_creq_addr,
    input  logic [len_w-1:0]  ic_creq_len,
    input  logic [strb_w-1:0] ic_creq_strb,
    input  logic [word_w-1:0] ic_creq_wdata,
    output logic              ic_cresp_ready,
    output logic              ic_cresp_last,
    output logic [word_w-1:0] ic_cresp_rdata,
    input  logic              dc_creq_valid,
    input  logic              dc_creq_write,
    input  logic [word_w-1:0] dc_creq_addr,
    input  logic [len_w-1:0]  dc_creq_len,
    input  logic [strb_w-1:0] dc_creq_strb,
    input  logic [word_w-1:0] dc_creq_wdata,
    output logic              dc_cresp_ready,
    output logic              dc_cresp_last,
    output logic [word_w-1:0] dc_cresp_rdata,
    output logic              creq_valid,
    output logic              creq_write,
    output logic [word_w-1:0] creq_addr,
    output logic [len_w-1:0]  creq_len,
    output logic [strb_w-1:0] creq_strb,
    output logic [word_w-1:0] creq_wdata,
    input  logic              cresp_ready,
    input  logic              cresp_last,
    input  logic [word_w-1:0] cresp_rdata
);
    logic busy_q;
    logic grant_dc_q;
    logic grant_dc;
    logic burst_end;

    // data side wins a fresh arbitration, then the grant sticks
    assign grant_dc = busy_q ? grant_dc_q : dc_creq_valid;
    assign burst_end = creq_valid && cresp_ready && cresp_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            grant_dc_q <= 1'b0;
        end else begin
            busy_q <= creq_valid && !burst_end;
            grant_dc_q <= grant_dc;
        end
    end

    assign {creq_valid, creq_write, creq_addr, creq_len, creq_strb, creq_wdata} = grant_dc
        ? {dc_creq_valid, dc_creq_write, dc_creq_addr, dc_creq_len, dc_creq_strb, dc_creq_wdata}
        : {ic_creq_valid, ic_creq_write, ic_creq_addr, ic_creq_len, ic_creq_strb, ic_creq_wdata};

    // loser sees no beats
    assign dc_cresp_ready = grant_dc && cresp_ready;
    assign dc_cresp_last = grant_dc && cresp_last;
    assign ic_cresp_ready = !grant_dc && cresp_ready;
    assign ic_cresp_last = !grant_dc && cresp_last;
    assign dc_cresp_rdata = cresp_rdata;
    assign ic_cresp_rdata = cresp_rdata;

    // a burst in flight keeps its master, so the forwarded request stays put
    a_grant_locked: assert property (
        @(posedge clk) disable iff (!rst_n)
        creq_valid && !burst_end |=> creq_valid && $stable(creq_addr) && $stable(creq_len)
    );

endmodule

// ==== logic/cache_manage.sv ====
`timescale 1ns/1ps

module cache_manage
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ireq_valid,
    input  logic [word_w-1:0] ireq_addr,
    output logic              iresp_data_ok,
    output logic [word_w-1:0] iresp_data,
    input  logic              dreq_valid,
    input  logic [word_w-1:0] dreq_addr,
    input  logic [strb_w-1:0] dreq_strb,
    input  logic [word_w-1:0] dreq_wdata,
    output logic              dresp_data_ok,
    output logic [word_w-1:0] dresp_data,
    output logic              exc_adel,
    output logic              exc_ades,
    output logic              creq_valid,
    output logic              creq_write,
    output logic [word_w-1:0] creq_addr,
    output logic [len_w-1:0]  creq_len,
    output logic [strb_w-1:0] creq_strb,
    output logic [word_w-1:0] creq_wdata,
    input  logic              cresp_ready,
    input  logic              cresp_last,
    input  logic [word_w-1:0] cresp_rdata,
    input  logic [2:0]        config_k0
);
    // translated requests
    logic              i_valid, i_uncached, d_valid, d_uncached;
    logic [word_w-1:0] i_paddr, d_paddr;

    // per-cache memory bus ports
    logic              ic_creq_valid, ic_creq_write, ic_cresp_ready, ic_cresp_last;
    logic [word_w-1:0] ic_creq_addr, ic_creq_wdata, ic_cresp_rdata;
    logic [len_w-1:0]  ic_creq_len;
    logic [strb_w-1:0] ic_creq_strb;
    logic              dc_creq_valid, dc_creq_write, dc_cresp_ready, dc_cresp_last;
    logic [word_w-1:0] dc_creq_addr, dc_creq_wdata, dc_cresp_rdata;
    logic [len_w-1:0]  dc_creq_len;
    logic [strb_w-1:0] dc_creq_strb;

    addr_translate translate (.*);

    icache icache (
        .clk,
        .rst_n,
        .req_valid(i_valid),
        .req_paddr(i_paddr),
        .req_uncached(i_uncached),
        .resp_data_ok(iresp_data_ok),
        .resp_data(iresp_data),
        .creq_valid(ic_creq_valid),
        .creq_write(ic_creq_write),
        .creq_addr(ic_creq_addr),
        .creq_len(ic_creq_len),
        .creq_strb(ic_creq_strb),
        .creq_wdata(ic_creq_wdata),
        .cresp_ready(ic_cresp_ready),
        .cresp_last(ic_cresp_last),
        .cresp_rdata(ic_cresp_rdata)
    );

    dcache dcache (
        .clk,
        .rst_n,
        .req_valid(d_valid),
        .req_paddr(d_paddr),
        .req_uncached(d_uncached),
        .req_strb(dreq_strb),
        .req_wdata(dreq_wdata),
        .resp_data_ok(dresp_data_ok),
        .resp_data(dresp_data),
        .creq_valid(dc_creq_valid),
        .creq_write(dc_creq_write),
        .creq_addr(dc_creq_addr),
        .creq_len(dc_creq_len),
        .creq_strb(dc_creq_strb),
        .creq_wdata(dc_creq_wdata),
        .cresp_ready(dc_cresp_ready),
        .cresp_last(dc_cresp_last),
        .cresp_rdata(dc_cresp_rdata)
    );

    bus_arbiter cbus_arbiter (.*);

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam time half_period = 20ns;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release just after an edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
    import bus_pkg::*;
#(
    parameter logic [31:0] seed = 32'h0
) (
    input  logic              clk,
    input  logic              creq_valid,
    input  logic              creq_write,
    input  logic [word_w-1:0] creq_addr,
    input  logic [len_w-1:0]  creq_len,
    input  logic [strb_w-1:0] creq_strb,
    input  logic [word_w-1:0] creq_wdata,
    output logic              cresp_ready,
    output logic              cresp_last,
    output logic [word_w-1:0] cresp_rdata
);
    localparam int depth = 1024;

    logic [word_w-1:0] mem [depth];
    logic [word_w-1:0] cur_addr;
    logic              cur_write;
    logic [strb_w-1:0] cur_strb;
    logic [word_w-1:0] cur_wdata;
    logic [9:0]        idx;
    int                beat;
    int                stall;

    initial begin
        for (int a = 0; a < depth; a++) begin
            mem[a] = a ^ 32'h5A5A_0000;
        end
        cresp_ready = 1'b0;
        cresp_last = 1'b0;
        cresp_rdata = '0;
        beat = 0;
        void'($urandom(seed));
        stall = $urandom_range(2);
        forever begin
            @(posedge clk);
            #1;
            // beat presented in the last cycle was taken at this edge
            if (cresp_ready) begin
                if (cur_write) begin
                    idx = cur_addr[11:2];
                    for (int b = 0; b < strb_w; b++) begin
                        if (cur_strb[b]) begin
                            mem[idx][8*b +: 8] = cur_wdata[8*b +: 8];
                        end
                    end
                end
                beat = cresp_last ? 0 : beat + 1;
                stall = $urandom_range(2);
            end
            cresp_ready = 1'b0;
            cresp_last = 1'b0;
            if (creq_valid && stall > 0) begin
                stall--;
            end else if (creq_valid) begin
                cur_addr = creq_addr;
                cur_write = creq_write;
                cur_strb = creq_strb;
                cur_wdata = creq_wdata;
                idx = creq_addr[11:2] + 10'(beat);
                cresp_rdata = mem[idx];
                cresp_ready = 1'b1;
                cresp_last = beat == int'(creq_len);
            end
        end
    end

endmodule

// ==== tests/tb_cache_manage.sv ====
`timescale 1ns/1ps

module tb_cache_manage
    import bus_pkg::*;
    import addr_map_pkg::*;
();
    logic              clk;
    logic              rst_n;
    logic              ireq_valid;
    logic [word_w-1:0] ireq_addr;
    logic              iresp_data_ok;
    logic [word_w-1:0] iresp_data;
    logic              dreq_valid;
    logic [word_w-1:0] dreq_addr;
    logic [strb_w-1:0] dreq_strb;
    logic [word_w-1:0] dreq_wdata;
    logic              dresp_data_ok;
    logic [word_w-1:0] dresp_data;
    logic              exc_adel;
    logic              exc_ades;
    logic              creq_valid;
    logic              creq_write;
    logic [word_w-1:0] creq_addr;
    logic [len_w-1:0]  creq_len;
    logic [strb_w-1:0] creq_strb;
    logic [word_w-1:0] creq_wdata;
    logic              cresp_ready;
    logic              cresp_last;
    logic [word_w-1:0] cresp_rdata;
    logic [2:0]        config_k0;

    int                errors = 0;
    int                test_errors_start;
    int                test_count;
    int                failed_tests;
    int                bus_cycles = 0;
    int                i_latency;
    int                d_latency;
    logic [word_w-1:0] i_rdata;
    logic [word_w-1:0] d_rdata;
    logic [word_w-1:0] burst_addr [$];
    logic [len_w-1:0]  burst_len [$];
    logic              burst_write [$];
    logic [strb_w-1:0] burst_strb [$];
    logic [word_w-1:0] burst_wdata [$];
    // every store so far, keyed by word index
    logic [word_w-1:0] shadow [int];

    clock_gen clocks (.*);
    mem_model #(.seed(32'h781c_a556)) memory (.*);
    cache_manage dut (.*);

    // bus activity sampled mid-cycle
    always @(negedge clk) begin
        if (creq_valid === 1'b1) begin
            bus_cycles++;
        end
        if (creq_valid === 1'b1 && cresp_ready && cresp_last) begin
            burst_addr.push_back(creq_addr);
            burst_len.push_back(creq_len);
            burst_write.push_back(creq_write);
            burst_strb.push_back(creq_strb);
            burst_wdata.push_back(creq_wdata);
        end
    end

    a_iresp_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) iresp_data_ok |=> !iresp_data_ok
    ) else note_failure("iresp_data_ok stayed high for more than one cycle");

    a_dresp_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) dresp_data_ok |=> !dresp_data_ok
    ) else note_failure("dresp_data_ok stayed high for more than one cycle");

    // word index xor constant, unless a store landed there
    function automatic logic [word_w-1:0] expected_word(input logic [word_w-1:0] addr);
        if (shadow.exists(int'(addr[11:2]))) begin
            return shadow[int'(addr[11:2])];
        end
        return {22'b0, addr[11:2]} ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [word_w-1:0] merge_bytes(input logic [word_w-1:0] old_word,
                                                      input logic [word_w-1:0] wdata,
                                                      input logic [strb_w-1:0] strb);
        logic [word_w-1:0] result;
        result = old_word;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("error %s expected %h actual %h", sig, expected, actual);
        end
    endtask

    task automatic check_burst_count(input int expected);
        assert (burst_addr.size() == expected)
            else note_failure($sformatf("expected %0d memory requests but saw %0d",
                                        expected, burst_addr.size()));
    endtask

    task automatic check_burst(input int i, input logic [word_w-1:0] addr,
                               input logic [len_w-1:0] len, input logic write);
        if (burst_addr.size() > i) begin
            check_value("creq_addr", addr, burst_addr[i]);
            check_value("creq_len", 32'(len), 32'(burst_len[i]));
            check_value("creq_write", 32'(write), 32'(burst_write[i]));
        end
    endtask

    task automatic check_write_beat(input int i, input logic [strb_w-1:0] strb,
                                    input logic [word_w-1:0] wdata);
        if (burst_strb.size() > i) begin
            check_value("creq_strb", 32'(strb), 32'(burst_strb[i]));
            check_value("creq_wdata", wdata, burst_wdata[i]);
        end
    endtask

    task automatic start_test();
        test_errors_start = errors;
        burst_addr.delete();
        burst_len.delete();
        burst_write.delete();
        burst_strb.delete();
        burst_wdata.delete();
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (errors != test_errors_start) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", test_count, name,
                 errors == test_errors_start ? "ok" : "failed");
    endtask

    // latency counts cycles after the one in which valid went up
    task automatic await_responses(input bit want_i, input bit want_d);
        int n;
        bit i_done;
        bit d_done;
        n = 0;
        i_done = !want_i;
        d_done = !want_d;
        while (!(i_done && d_done) && n < 200) begin
            @(negedge clk);
            n++;
            if (!i_done && iresp_data_ok) begin
                i_done = 1'b1;
                i_rdata = iresp_data;
                i_latency = n - 1;
            end
            if (!d_done && dresp_data_ok) begin
                d_done = 1'b1;
                d_rdata = dresp_data;
                d_latency = n - 1;
            end
            @(posedge clk);
            #1;
            if (i_done) begin
                ireq_valid = 1'b0;
            end
            if (d_done) begin
                dreq_valid = 1'b0;
            end
        end
        if (!(i_done && d_done)) begin
            note_failure("timed out after 200 cycles waiting for data_ok");
            ireq_valid = 1'b0;
            dreq_valid = 1'b0;
        end
    endtask

    task automatic fetch(input logic [word_w-1:0] va);
        @(posedge clk);
        #1;
        ireq_addr = va;
        ireq_valid = 1'b1;
        await_responses(1'b1, 1'b0);
    endtask

    task automatic data_access(input logic [word_w-1:0] va, input logic [strb_w-1:0] strb,
                               input logic [word_w-1:0] wdata);
        @(posedge clk);
        #1;
        dreq_addr = va;
        dreq_strb = strb;
        dreq_wdata = wdata;
        dreq_valid = 1'b1;
        await_responses(1'b0, 1'b1);
        if (strb != '0) begin
            shadow[int'(va[11:2])] = merge_bytes(expected_word(va), wdata, strb);
        end
    endtask

    // request is held 20 cycles, nothing may come back
    task automatic expect_fault(input logic [word_w-1:0] va, input logic [strb_w-1:0] strb);
        bit quiet;
        @(posedge clk);
        #1;
        dreq_addr = va;
        dreq_strb = strb;
        dreq_wdata = '1;
        dreq_valid = 1'b1;
        quiet = 1'b1;
        @(negedge clk);
        check_value("exc_adel", 32'(strb == '0), 32'(exc_adel));
        check_value("exc_ades", 32'(strb != '0), 32'(exc_ades));
        for (int n = 0; n < 20; n++) begin
            if (creq_valid || dresp_data_ok) begin
                quiet = 1'b0;
            end
            @(negedge clk);
        end
        assert (quiet) else note_failure("misaligned access reached memory or was answered");
        @(posedge clk);
        #1;
        dreq_valid = 1'b0;
    endtask

    initial begin
        int n;
        int cycles_before;
        test_count = 0;
        failed_tests = 0;
        ireq_valid = 1'b0;
        ireq_addr = '0;
        dreq_valid = 1'b0;
        dreq_addr = '0;
        dreq_strb = '0;
        dreq_wdata = '0;
        config_k0 = k0_cached;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        assert (rst_n === 1'b1) else note_failure("reset was never released");

        start_test();
        fetch(32'hA000_0100);
        check_value("iresp_data", expected_word(32'h100), i_rdata);
        check_burst_count(1);
        check_burst(0, 32'h100, len_single, 1'b0);
        end_test("uncached fetch");

        start_test();
        fetch(32'h8000_0204);
        check_value("iresp_data", expected_word(32'h204), i_rdata);
        cycles_before = bus_cycles;
        fetch(32'h8000_020C);
        check_value("iresp_data", expected_word(32'h20C), i_rdata);
        check_burst_count(1);
        check_burst(0, 32'h200, len_line, 1'b0);
        assert (bus_cycles == cycles_before && i_latency == 1)
            else note_failure("fetch hit used the memory bus or was not answered next cycle");
        end_test("cached fetch");

        start_test();
        data_access(32'h8000_0308, '0, '0);
        check_value("dresp_data", expected_word(32'h308), d_rdata);
        data_access(32'h8000_0308, 4'b0110, 32'h1234_ABCD);
        data_access(32'h8000_0308, '0, '0);
        check_value("dresp_data", expected_word(32'h308), d_rdata);
        assert (d_latency == 1) else note_failure("load after the store did not hit");
        data_access(32'hA000_0308, '0, '0);
        check_value("dresp_data", expected_word(32'h308), d_rdata);
        check_burst_count(3);
        check_burst(1, 32'h308, len_single, 1'b1);
        check_write_beat(1, 4'b0110, 32'h1234_ABCD);
        end_test("write-through");

        start_test();
        config_k0 = 3'd2;
        data_access(32'h8000_0400, '0, '0);
        check_value("dresp_data", expected_word(32'h400), d_rdata);
        data_access(32'h8000_0400, '0, '0);
        check_value("dresp_data", expected_word(32'h400), d_rdata);
        check_burst_count(2);
        check_burst(0, 32'h400, len_single, 1'b0);
        check_burst(1, 32'h400, len_single, 1'b0);
        config_k0 = k0_cached;
        end_test("kseg0 uncached by config_k0");

        start_test();
        @(posedge clk);
        #1;
        ireq_addr = 32'h8000_0500;
        ireq_valid = 1'b1;
        dreq_addr = 32'h8000_0614;
        dreq_strb = '0;
        dreq_valid = 1'b1;
        await_responses(1'b1, 1'b1);
        check_value("dresp_data", expected_word(32'h614), d_rdata);
        check_value("iresp_data", expected_word(32'h500), i_rdata);
        check_burst_count(2);
        check_burst(0, 32'h610, len_line, 1'b0);
        check_burst(1, 32'h500, len_line, 1'b0);
        end_test("contention");

        start_test();
        expect_fault(32'h8000_0702, '0);
        expect_fault(32'h8000_0701, 4'b1111);
        end_test("misaligned access");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/bus_pkg.sv
common/addr_map_pkg.sv
logic/addr_translate.sv
icache/icache.sv
dcache/dcache.sv
logic/bus_arbiter.sv
logic/cache_manage.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/tb_cache_manage.sv
